//--- verif/fetch_stim.txt
// flags digits: credit_ret resolve_vld branch jump taken pred_taken pred_hit gap
// then resolve pc, resolve target, predicted target, expect vld/flush/taken/hit, pc, target
// Boot sequence with no credit returns until the stall
00000000 00000000 00000000 00000000 1000 00000000 00000000
00000000 00000000 00000000 00000000 1000 00000004 00000000
00000000 00000000 00000000 00000000 1000 00000008 00000000
00000000 00000000 00000000 00000000 1000 0000000c 00000000
00000000 00000000 00000000 00000000 0000 00000010 00000000
00000001 00000000 00000000 00000000 0000 00000010 00000000
10000000 00000000 00000000 00000000 0000 00000010 00000000
10000000 00000000 00000000 00000000 1000 00000010 00000000
10000000 00000000 00000000 00000000 1000 00000014 00000000
10000000 00000000 00000000 00000000 1000 00000018 00000000
// Branch at 0x14 taken but predicted not taken
11101000 00000014 00000040 00000000 0100 0000001c 00000000
10000000 00000000 00000000 00000000 1000 00000040 00000000
10000000 00000000 00000000 00000000 1000 00000044 00000000
11011000 00000044 00000010 00000000 0100 00000048 00000000
10000000 00000000 00000000 00000000 1000 00000010 00000000
10000000 00000000 00000000 00000000 1011 00000014 00000040
// Counter walks up then down
11101110 00000014 00000040 00000040 1000 00000040 00000000
10000000 00000000 00000000 00000000 1011 00000044 00000010
11100110 00000014 00000040 00000040 0100 00000010 00000000
10000000 00000000 00000000 00000000 1000 00000018 00000000
10000000 00000000 00000000 00000000 1000 0000001c 00000000
11011000 0000001c 00000010 00000000 0100 00000020 00000000
10000000 00000000 00000000 00000000 1000 00000010 00000000
10000000 00000000 00000000 00000000 1011 00000014 00000040
11100110 00000014 00000040 00000040 0100 00000040 00000000
10000000 00000000 00000000 00000000 1000 00000018 00000000
10000000 00000000 00000000 00000000 1011 0000001c 00000010
10000000 00000000 00000000 00000000 1000 00000010 00000000
10000000 00000000 00000000 00000000 1001 00000014 00000040
10000000 00000000 00000000 00000000 1000 00000018 00000000
// Jump at 0x1c moves its target to 0x80
10000000 00000000 00000000 00000000 1011 0000001c 00000010
11011110 0000001c 00000080 00000010 0100 00000010 00000000
10000000 00000000 00000000 00000000 1000 00000080 00000000
10000000 00000000 00000000 00000000 1000 00000084 00000000
11011000 00000084 00000018 00000000 0100 00000088 00000000
10000000 00000000 00000000 00000000 1000 00000018 00000000
10000000 00000000 00000000 00000000 1011 0000001c 00000080
10000000 00000000 00000000 00000000 1000 00000080 00000000
10000000 00000000 00000000 00000000 1011 00000084 00000018
// Resolve without branch or jump flag is ignored
11001000 00000018 00000100 00000000 1000 00000018 00000000
10000000 00000000 00000000 00000000 1011 0000001c 00000080
10000000 00000000 00000000 00000000 1000 00000080 00000000
10000000 00000000 00000000 00000000 1011 00000084 00000018
10000000 00000000 00000000 00000000 1000 00000018 00000000
ffffffff

//--- compile.f
hw/fetch_pkg.sv
hw/bpu_pkg.sv
hw/btb.sv
hw/branch_resolve.sv
hw/fetch_credit.sv
hw/pc_gen.sv
hw/fetch_frontend.sv
verif/tb_clk_gen.sv
verif/tb_fetch_frontend.sv

//--- Bender.yml
package:
  name: fetch_frontend

sources:
  - hw/fetch_pkg.sv
  - hw/bpu_pkg.sv
  - hw/btb.sv
  - hw/branch_resolve.sv
  - hw/fetch_credit.sv
  - hw/pc_gen.sv
  - hw/fetch_frontend.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_fetch_frontend.sv

//--- verif/tb_fetch_frontend.sv
`timescale 1ns/100ps

module tb_fetch_frontend;

    localparam int INDEX_WIDTH = 6;
    localparam int MAX_CREDITS = 4;

    // Seven hex words per stimulus record
    localparam int REC_WORDS = 7;
    localparam int MAX_RECS  = 128;
    localparam logic [31:0] END_MARK = 32'hffff_ffff;
    localparam logic [31:0] SEED     = 32'h0eff64c2;

    // Input flag digits counted from the right
    localparam int F_RET    = 7;
    localparam int F_RVLD   = 6;
    localparam int F_BRANCH = 5;
    localparam int F_JUMP   = 4;
    localparam int F_TAKEN  = 3;
    localparam int F_PTAKEN = 2;
    localparam int F_PHIT   = 1;
    localparam int F_GAP    = 0;

    // Digits of the expected flag word
    localparam int E_VLD   = 3;
    localparam int E_FLUSH = 2;
    localparam int E_TAKEN = 1;
    localparam int E_HIT   = 0;

    logic                   clk;
    logic                   rstn;
    logic                   credit_ret;
    logic                   resolve_vld;
    fetch_pkg::resolve_t    resolve;
    logic                   fetch_vld;
    fetch_pkg::fetch_pkt_t  fetch_pkt;
    logic                   flush;

    logic [31:0] stim_mem [0:MAX_RECS*REC_WORDS-1];
    int          rec_count;
    int          cycle_count = 0;
    int          cycle_limit = MAX_RECS + 100;

    tb_clk_gen #(
        .PERIOD_NS    (40),
        .RESET_CYCLES (10)
    ) u_clk_gen (
        .o_clk  (clk),
        .o_rstn (rstn)
    );

    fetch_frontend #(
        .INDEX_WIDTH (INDEX_WIDTH),
        .MAX_CREDITS (MAX_CREDITS)
    ) dut0 (
        .i_clk         (clk),
        .i_rstn        (rstn),
        .i_credit_ret  (credit_ret),
        .i_resolve_vld (resolve_vld),
        .i_resolve     (resolve),
        .o_fetch_vld   (fetch_vld),
        .o_fetch       (fetch_pkt),
        .o_flush       (flush)
    );

    function automatic logic flag_at(input logic [31:0] word, input int pos);
        return word[4*pos];
    endfunction

    // Execute outcome plus the prediction the packet carried
    function automatic fetch_pkg::resolve_t build_resolve(
        input logic [31:0] flags,
        input logic [31:0] rpc,
        input logic [31:0] rtgt,
        input logic [31:0] ptgt
    );
        fetch_pkg::resolve_t rec;
        rec.pc         = rpc;
        rec.branch     = flag_at(flags, F_BRANCH);
        rec.jump       = flag_at(flags, F_JUMP);
        rec.taken      = flag_at(flags, F_TAKEN);
        rec.target     = rtgt;
        rec.pkt.pc     = rpc;
        rec.pkt.taken  = flag_at(flags, F_PTAKEN);
        rec.pkt.hit    = flag_at(flags, F_PHIT);
        rec.pkt.target = ptgt;
        return rec;
    endfunction

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped on the first failure");
    endtask

    task automatic compare_values(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic drive_record(input int r);
        logic [31:0] flags;
        flags = stim_mem[r*REC_WORDS];
        credit_ret  <= flag_at(flags, F_RET);
        resolve_vld <= flag_at(flags, F_RVLD);
        resolve     <= build_resolve(flags, stim_mem[r*REC_WORDS+1],
                                     stim_mem[r*REC_WORDS+2], stim_mem[r*REC_WORDS+3]);
    endtask

    task automatic check_record(input int r);
        logic [31:0] exp_flags;
        logic [31:0] exp_pc;
        logic [31:0] exp_target;
        exp_flags  = stim_mem[r*REC_WORDS+4];
        exp_pc     = stim_mem[r*REC_WORDS+5];
        exp_target = stim_mem[r*REC_WORDS+6];
        compare_values($sformatf("record %0d o_fetch_vld", r), fetch_vld,
                       flag_at(exp_flags, E_VLD));
        compare_values($sformatf("record %0d o_flush", r), flush,
                       flag_at(exp_flags, E_FLUSH));
        compare_values($sformatf("record %0d o_fetch.pc", r), fetch_pkt.pc, exp_pc);
        compare_values($sformatf("record %0d o_fetch.taken", r), fetch_pkt.taken,
                       flag_at(exp_flags, E_TAKEN));
        compare_values($sformatf("record %0d o_fetch.hit", r), fetch_pkt.hit,
                       flag_at(exp_flags, E_HIT));
        // Stored target only means something on a hit
        if (flag_at(exp_flags, E_HIT)) begin
            compare_values($sformatf("record %0d o_fetch.target", r), fetch_pkt.target,
                           exp_target);
        end
    endtask

    // Stalled cycles with no credit left hold the PC
    task automatic idle_cycles(input int count, input logic [31:0] held_pc);
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            credit_ret  <= 1'b0;
            resolve_vld <= 1'b0;
            resolve     <= '0;
            @(negedge clk);
            compare_values("o_fetch_vld in idle gap", fetch_vld, 1'b0);
            compare_values("o_flush in idle gap", flush, 1'b0);
            compare_values("o_fetch.pc in idle gap", fetch_pkt.pc, held_pc);
        end
    endtask

    always @(posedge clk) begin
        if (rstn) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= cycle_limit) begin
                $display("Timeout: the run did not end within %0d cycles", cycle_limit);
                abort_run();
            end
        end
    end

    initial begin
        int gap_len;
        credit_ret  = 1'b0;
        resolve_vld = 1'b0;
        resolve     = '0;
        void'($urandom(SEED));

        $readmemh("verif/fetch_stim.txt", stim_mem);
        rec_count = 0;
        while (rec_count < MAX_RECS && stim_mem[rec_count*REC_WORDS] !== END_MARK) begin
            rec_count++;
        end
        if (rec_count == 0 || rec_count == MAX_RECS) begin
            $display("Stimulus file verif/fetch_stim.txt is empty or lacks its end marker");
            abort_run();
        end
        cycle_limit = rec_count + 100;

        @(posedge rstn);
        @(negedge clk);
        compare_values("o_fetch_vld after reset", fetch_vld, 1'b0);
        compare_values("o_flush after reset", flush, 1'b0);
        compare_values("o_fetch.pc after reset", fetch_pkt.pc, fetch_pkg::BOOT_PC);

        for (int r = 0; r < rec_count; r++) begin
            @(posedge clk);
            drive_record(r);
            @(negedge clk);
            check_record(r);
            if (flag_at(stim_mem[r*REC_WORDS], F_GAP)) begin
                gap_len = $urandom_range(3, 0);
                idle_cycles(gap_len, stim_mem[r*REC_WORDS+5]);
            end
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- verif/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic o_clk,
    output logic o_rstn
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Reset drops on a rising edge so the DUT sees a clean release
    initial begin
        o_rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rstn <= 1'b1;
    end

endmodule

//--- hw/fetch_frontend.sv
`timescale 1ns/100ps

module fetch_frontend #(
    parameter int INDEX_WIDTH = 6,
    parameter int MAX_CREDITS = 4
) (
    input  logic                   i_clk,
    input  logic                   i_rstn,
    input  logic                   i_credit_ret,
    input  logic                   i_resolve_vld,
    input  fetch_pkg::resolve_t    i_resolve,
    output logic                   o_fetch_vld,
    output fetch_pkg::fetch_pkt_t  o_fetch,
    output logic                   o_flush
);

    bpu_pkg::btb_lookup_t        lookup;
    bpu_pkg::btb_update_t        update;
    fetch_pkg::redirect_t        redirect;
    logic [fetch_pkg::XLEN-1:0]  fetch_pc;
    logic                        fetch_vld;
    logic                        credit_avail;

    // Predictor, indexed by the current PC
    btb #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_btb (
        .i_clk    (i_clk),
        .i_rstn   (i_rstn),
        .i_pc     (fetch_pc),
        .i_update (update),
        .o_lookup (lookup)
    );

    // Misprediction check on the execute outcome
    branch_resolve u_branch_resolve (
        .i_resolve_vld (i_resolve_vld),
        .i_resolve     (i_resolve),
        .o_redirect    (redirect),
        .o_update      (update)
    );

    fetch_credit #(
        .MAX_CREDITS (MAX_CREDITS)
    ) u_fetch_credit (
        .i_clk          (i_clk),
        .i_rstn         (i_rstn),
        .i_send         (fetch_vld),
        .i_credit_ret   (i_credit_ret),
        .o_credit_avail (credit_avail)
    );

    pc_gen u_pc_gen (
        .i_clk          (i_clk),
        .i_rstn         (i_rstn),
        .i_lookup       (lookup),
        .i_redirect     (redirect),
        .i_credit_avail (credit_avail),
        .o_pc           (fetch_pc),
        .o_fetch_vld    (fetch_vld),
        .o_fetch        (o_fetch)
    );

    assign o_fetch_vld = fetch_vld;

    // Decode drops its wrong-path packets on this
    assign o_flush = redirect.valid;

endmodule

//--- hw/pc_gen.sv
`timescale 1ns/100ps

module pc_gen (
    input  logic                        i_clk,
    input  logic                        i_rstn,
    input  bpu_pkg::btb_lookup_t        i_lookup,
    input  fetch_pkg::redirect_t        i_redirect,
    input  logic                        i_credit_avail,
    output logic [fetch_pkg::XLEN-1:0]  o_pc,
    output logic                        o_fetch_vld,
    output fetch_pkg::fetch_pkt_t       o_fetch
);

    logic [fetch_pkg::XLEN-1:0] pc_q;
    logic [fetch_pkg::XLEN-1:0] pc_plus4;
    logic [fetch_pkg::XLEN-1:0] pc_next;
    logic                       send;

    // A redirect squashes the packet fetched this cycle
    assign send = i_credit_avail && !i_redirect.valid;

    assign pc_plus4 = pc_q + fetch_pkg::XLEN'(4);

    // Redirect first, then prediction on send, else hold
    always_comb begin
        if (i_redirect.valid) begin
            pc_next = i_redirect.pc;
        end else if (send) begin
            if (i_lookup.taken) begin
                pc_next = i_lookup.target;
            end else begin
                pc_next = pc_plus4;
            end
        end else begin
            pc_next = pc_q;
        end
    end

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            pc_q <= fetch_pkg::BOOT_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    // Packet carries the prediction seen at fetch
    always_comb begin
        o_fetch.pc     = pc_q;
        o_fetch.taken  = i_lookup.taken;
        o_fetch.hit    = i_lookup.hit;
        o_fetch.target = i_lookup.target;
    end

    assign o_fetch_vld = send;
    assign o_pc        = pc_q;

endmodule

//--- hw/fetch_credit.sv
`timescale 1ns/100ps

module fetch_credit #(
    parameter int MAX_CREDITS = 4
) (
    input  logic i_clk,
    input  logic i_rstn,
    input  logic i_send,
    input  logic i_credit_ret,
    output logic o_credit_avail
);

    localparam int CNT_WIDTH = $clog2(MAX_CREDITS + 1);
    localparam logic [CNT_WIDTH-1:0] CNT_MAX = CNT_WIDTH'(MAX_CREDITS);

    logic [CNT_WIDTH-1:0] count_q;
    logic [CNT_WIDTH-1:0] count_next;
    logic                 avail_q;

    always_comb begin
        count_next = count_q;
        case ({i_send, i_credit_ret})
            2'b10: begin
                if (count_q != '0) begin
                    count_next = count_q - 1'b1;
                end
            end
            // Return at full count is dropped
            2'b01: begin
                if (count_q < CNT_MAX) begin
                    count_next = count_q + 1'b1;
                end
            end
            default: count_next = count_q;
        endcase
    end

    // Available flag tracks the count, low while in reset
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            count_q <= CNT_MAX;
            avail_q <= 1'b0;
        end else begin
            count_q <= count_next;
            avail_q <= (count_next != '0);
        end
    end

    assign o_credit_avail = avail_q;

endmodule

//--- hw/branch_resolve.sv
`timescale 1ns/100ps

module branch_resolve (
    input  logic                  i_resolve_vld,
    input  fetch_pkg::resolve_t   i_resolve,
    output fetch_pkg::redirect_t  o_redirect,
    output bpu_pkg::btb_update_t  o_update
);

    logic                        is_ctrl;
    logic                        pred_taken;
    logic                        wrong_dir_taken;
    logic                        wrong_target;
    logic                        wrong_dir_not_taken;
    logic [fetch_pkg::XLEN-1:0]  fall_through;

    // Plain instructions carry no outcome
    assign is_ctrl = i_resolve_vld && (i_resolve.branch || i_resolve.jump);

    assign pred_taken   = i_resolve.pkt.taken;
    assign fall_through = i_resolve.pc + fetch_pkg::XLEN'(4);

    assign wrong_dir_taken     = i_resolve.taken && !pred_taken;
    assign wrong_target        = i_resolve.taken && pred_taken &&
                                 (i_resolve.pkt.target != i_resolve.target);
    assign wrong_dir_not_taken = !i_resolve.taken && pred_taken;

    always_comb begin
        o_redirect.valid = is_ctrl &&
                           (wrong_dir_taken || wrong_target || wrong_dir_not_taken);
        // Taken goes to the target, not taken falls through
        if (i_resolve.taken) begin
            o_redirect.pc = i_resolve.target;
        end else begin
            o_redirect.pc = fall_through;
        end
    end

    // Every resolved branch or jump trains the buffer
    always_comb begin
        o_update.valid  = is_ctrl;
        o_update.pc     = i_resolve.pc;
        o_update.taken  = i_resolve.taken;
        o_update.jump   = i_resolve.jump;
        o_update.target = i_resolve.target;
    end

endmodule

//--- hw/btb.sv
`timescale 1ns/100ps

module btb #(
    parameter int INDEX_WIDTH = 6
) (
    input  logic                        i_clk,
    input  logic                        i_rstn,
    input  logic [fetch_pkg::XLEN-1:0]  i_pc,
    input  bpu_pkg::btb_update_t        i_update,
    output bpu_pkg::btb_lookup_t        o_lookup
);

    localparam int ENTRIES   = 2 ** INDEX_WIDTH;
    localparam int TAG_WIDTH = fetch_pkg::XLEN - INDEX_WIDTH - 2;

    logic                        valid_q  [ENTRIES];
    logic [TAG_WIDTH-1:0]        tag_q    [ENTRIES];
    logic [fetch_pkg::XLEN-1:0]  target_q [ENTRIES];
    logic                        jump_q   [ENTRIES];
    bpu_pkg::ctr_t               ctr_q    [ENTRIES];

    logic [INDEX_WIDTH-1:0]      rd_index;
    logic [TAG_WIDTH-1:0]        rd_tag;
    logic [INDEX_WIDTH-1:0]      wr_index;
    logic [TAG_WIDTH-1:0]        wr_tag;
    logic                        wr_hit;
    logic                        wr_en;
    bpu_pkg::ctr_t               ctr_next;

    // Word-aligned PCs, so the byte offset is skipped
    assign rd_index = i_pc[INDEX_WIDTH+1:2];
    assign rd_tag   = i_pc[fetch_pkg::XLEN-1:INDEX_WIDTH+2];
    assign wr_index = i_update.pc[INDEX_WIDTH+1:2];
    assign wr_tag   = i_update.pc[fetch_pkg::XLEN-1:INDEX_WIDTH+2];

    // Lookup for the fetch PC
    always_comb begin
        o_lookup.hit    = valid_q[rd_index] && (tag_q[rd_index] == rd_tag);
        // Upper counter bit set means the taken half
        o_lookup.taken  = o_lookup.hit && (jump_q[rd_index] || ctr_q[rd_index][1]);
        o_lookup.target = target_q[rd_index];
    end

    assign wr_hit = valid_q[wr_index] && (tag_q[wr_index] == wr_tag);

    // Hits always write, misses only allocate when taken
    assign wr_en = i_update.valid && (wr_hit || i_update.taken);

    // Saturating step toward the outcome
    always_comb begin
        ctr_next = ctr_q[wr_index];
        if (!wr_hit) begin
            ctr_next = bpu_pkg::CTR_ALLOC;
        end else if (i_update.taken) begin
            if (ctr_q[wr_index] != bpu_pkg::CTR_ST) begin
                ctr_next = bpu_pkg::ctr_t'(ctr_q[wr_index] + 2'd1);
            end
        end else begin
            if (ctr_q[wr_index] != bpu_pkg::CTR_SNT) begin
                ctr_next = bpu_pkg::ctr_t'(ctr_q[wr_index] - 2'd1);
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            for (int i = 0; i < ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (wr_en) begin
            valid_q[wr_index] <= 1'b1;
        end
    end

    // Entry payload
    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            tag_q[wr_index]    <= wr_tag;
            target_q[wr_index] <= i_update.target;
            jump_q[wr_index]   <= i_update.jump;
            ctr_q[wr_index]    <= ctr_next;
        end
    end

endmodule

//--- hw/bpu_pkg.sv
package bpu_pkg;

    // Two-bit saturating direction counter
    typedef enum logic [1:0] {
        CTR_SNT = 2'd0,
        CTR_WNT = 2'd1,
        CTR_WT  = 2'd2,
        CTR_ST  = 2'd3
    } ctr_t;

    // A fresh entry starts one step into the taken half
    localparam ctr_t CTR_ALLOC = CTR_WT;

    // Answer for the current fetch PC
    typedef struct packed {
        logic                        hit;
        logic                        taken;
        logic [fetch_pkg::XLEN-1:0]  target;
    } btb_lookup_t;

    // Write command from branch resolution
    typedef struct packed {
        logic                        valid;
        logic [fetch_pkg::XLEN-1:0]  pc;
        logic                        taken;
        logic                        jump;
        logic [fetch_pkg::XLEN-1:0]  target;
    } btb_update_t;

endpackage

//--- hw/fetch_pkg.sv
package fetch_pkg;

    // Address width of the front end
    localparam int XLEN = 32;

    // Fetch starts here when reset is released
    localparam logic [XLEN-1:0] BOOT_PC = 32'h0000_0000;

    // One fetch packet handed to decode
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic            taken;
        logic            hit;
        logic [XLEN-1:0] target;
    } fetch_pkt_t;

    // Branch outcome returned by execute
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic            branch;
        logic            jump;
        logic            taken;
        logic [XLEN-1:0] target;
        // Prediction as it left the front end
        fetch_pkt_t      pkt;
    } resolve_t;

    // Fetch redirect after a misprediction
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
    } redirect_t;

endpackage
